// ==== common/mpu_consts.svh ====
`ifndef MPU_CONSTS_SVH
`define MPU_CONSTS_SVH

// Opcode values
// Codes 5 to 15 are treated as none
`define MPU_OP_NONE 4'd0
`define MPU_OP_MASK 4'd1
`define MPU_OP_CMP  4'd2
`define MPU_OP_LT   4'd3
`define MPU_OP_ADD  4'd4

// Register file geometry
`define MPU_DATA_W   64
`define MPU_NUM_REGS 4

// Instruction word width
`define MPU_INSTR_W 32

// Instruction field positions
// Bits 31:26 are ignored
`define MPU_OP_LO   0
`define MPU_OP_HI   3
`define MPU_SIZE_LO 4
`define MPU_SIZE_HI 5
`define MPU_S0_LO   6
`define MPU_S0_HI   8
`define MPU_S1_LO   9
`define MPU_S1_HI   11
`define MPU_S2_LO   12
`define MPU_S2_HI   14
`define MPU_SRES_LO 15
`define MPU_SRES_HI 17
`define MPU_RA_LO   18
`define MPU_RA_HI   19
`define MPU_RB_LO   20
`define MPU_RB_HI   21
`define MPU_RC_LO   22
`define MPU_RC_HI   23
`define MPU_RD_LO   24
`define MPU_RD_HI   25

`endif

// ==== common/mpu_data_pkg.sv ====
`default_nettype none

`include "mpu_consts.svh"

package mpu_data_pkg;

  // Register and operand value
  typedef logic [`MPU_DATA_W-1:0] word_t;

  // Bit position of a lane inside a word
  // Wide enough for any offset below the data width
  typedef logic [$clog2(`MPU_DATA_W)-1:0] bit_off_t;

  // Field width in bits
  // One bit more than the offset so that a full 64-bit field fits
  typedef logic [$clog2(`MPU_DATA_W):0] field_w_t;

  // Index into the register file
  typedef logic [$clog2(`MPU_NUM_REGS)-1:0] reg_idx_t;

endpackage

`default_nettype wire

// ==== common/mpu_isa_pkg.sv ====
`default_nettype none

`include "mpu_consts.svh"

package mpu_isa_pkg;

  // Raw instruction as issued by the host
  typedef logic [`MPU_INSTR_W-1:0] instr_t;

  // Operation code
  // 0 none, 1 mask check, 2 masked equality, 3 less-than, 4 add
  typedef logic [`MPU_OP_HI-`MPU_OP_LO:0] opcode_t;

  // Field size code
  // Field width is 8 shifted left by the code
  // 0 byte, 1 half, 2 word, 3 double
  typedef logic [`MPU_SIZE_HI-`MPU_SIZE_LO:0] size_code_t;

  // Lane selector within a register
  // Lane offset is selector times field width, truncated to the offset width
  typedef logic [`MPU_S0_HI-`MPU_S0_LO:0] lane_sel_t;

endpackage

`default_nettype wire

// ==== hdl/mpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mpu_consts.svh"

module mpu_decode
  import mpu_data_pkg::*, mpu_isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     instr_valid,
  input  instr_t   instr,
  output logic     exe_valid,
  output logic     exe_write,
  output opcode_t  exe_op,
  output word_t    field_mask,
  output word_t    res_mask,
  output bit_off_t off0,
  output bit_off_t off1,
  output bit_off_t off2,
  output bit_off_t off_res,
  output reg_idx_t ra,
  output reg_idx_t rb,
  output reg_idx_t rc,
  output reg_idx_t rd
);

  // Raw instruction fields
  opcode_t    op_in;
  size_code_t size_in;
  lane_sel_t  s0_in;
  lane_sel_t  s1_in;
  lane_sel_t  s2_in;
  lane_sel_t  sres_in;

  // Decoded values ahead of the register stage
  opcode_t  op_class;
  logic     op_real;
  field_w_t width;
  word_t    mask_d;
  bit_off_t off_res_d;

  // Lane offset is sel * width, keep only the low bits
  // so a 64-bit field always lands at offset 0
  function automatic bit_off_t lane_off(lane_sel_t sel, field_w_t w);
    logic [$bits(lane_sel_t)+$bits(field_w_t)-1:0] prod;
    prod = sel * w;
    return prod[$bits(bit_off_t)-1:0];
  endfunction

  assign op_in   = instr[`MPU_OP_HI:`MPU_OP_LO];
  assign size_in = instr[`MPU_SIZE_HI:`MPU_SIZE_LO];
  assign s0_in   = instr[`MPU_S0_HI:`MPU_S0_LO];
  assign s1_in   = instr[`MPU_S1_HI:`MPU_S1_LO];
  assign s2_in   = instr[`MPU_S2_HI:`MPU_S2_LO];
  assign sres_in = instr[`MPU_SRES_HI:`MPU_SRES_LO];

  // Only the four real operations survive, everything else becomes none
  always_comb begin
    case (op_in)
      `MPU_OP_MASK, `MPU_OP_CMP, `MPU_OP_LT, `MPU_OP_ADD: begin
        op_class = op_in;
        op_real  = 1'b1;
      end
      default: begin
        op_class = `MPU_OP_NONE;
        op_real  = 1'b0;
      end
    endcase
  end

  // 8, 16, 32 or 64 bits
  assign width = field_w_t'(8) << size_in;

  // Low-bit mask of the field
  // Shift by 64 clears everything so the inverse is all ones
  assign mask_d    = ~(~word_t'(0) << width);
  assign off_res_d = lane_off(sres_in, width);

  // Control side of the stage
  always_ff @(posedge clk) begin
    if (rst) begin
      exe_valid <= 1'b0;
      exe_write <= 1'b0;
    end else begin
      exe_valid <= instr_valid;
      exe_write <= instr_valid && op_real;
    end
  end

  // Payload side, captured only on an issue strobe
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      exe_op     <= op_class;
      field_mask <= mask_d;
      res_mask   <= mask_d << off_res_d;
      off0       <= lane_off(s0_in, width);
      off1       <= lane_off(s1_in, width);
      off2       <= lane_off(s2_in, width);
      off_res    <= off_res_d;
      ra         <= instr[`MPU_RA_HI:`MPU_RA_LO];
      rb         <= instr[`MPU_RB_HI:`MPU_RB_LO];
      rc         <= instr[`MPU_RC_HI:`MPU_RC_LO];
      rd         <= instr[`MPU_RD_HI:`MPU_RD_LO];
    end
  end

endmodule

`default_nettype wire

// ==== mpu_alu/mpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mpu_consts.svh"

module mpu_alu
  import mpu_data_pkg::*, mpu_isa_pkg::*;
(
  input  opcode_t  exe_op,
  input  word_t    field_mask,
  input  bit_off_t off0,
  input  bit_off_t off1,
  input  bit_off_t off2,
  input  bit_off_t off_res,
  input  word_t    o0,
  input  word_t    o1,
  input  word_t    o2,
  output word_t    res
);

  // Operand fields moved down to bit 0
  word_t a;
  word_t b;
  word_t c;

  // Per-operation results
  logic  mask_ok;
  logic  cmp_eq;
  logic  lt;
  word_t sum;

  // Selected result before the lane shift
  word_t sel_res;

  // Bits above the field are cleared
  assign a = (o0 >> off0) & field_mask;
  assign b = (o1 >> off1) & field_mask;
  assign c = (o2 >> off2) & field_mask;

  // Mask check
  // b is the inverted zero-allowed mask, set where a zero is forbidden
  // c is the one-allowed mask, set where a one is allowed
  // Any forbidden zero or forbidden one fails the check
  assign mask_ok = ((~a & b) | (a & ~c)) == word_t'(0);

  // Equality on the bits selected by c
  assign cmp_eq = (a & c) == (b & c);

  // Unsigned compare
  assign lt = a < b;

  // Carry out of the field is dropped
  assign sum = (b + c) & field_mask;

  // Booleans are zero-extended into the lane
  always_comb begin
    case (exe_op)
      `MPU_OP_MASK: sel_res = word_t'(mask_ok);
      `MPU_OP_CMP:  sel_res = word_t'(cmp_eq);
      `MPU_OP_LT:   sel_res = word_t'(lt);
      `MPU_OP_ADD:  sel_res = sum;
      default:      sel_res = word_t'(0);
    endcase
  end

  // Align with the destination lane
  assign res = sel_res << off_res;

endmodule

`default_nettype wire

// ==== hdl/mpu_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mpu_consts.svh"

module mpu_result
  import mpu_data_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     wr_en,
  input  reg_idx_t wr_addr,
  input  word_t    wr_data,
  input  logic     exe_valid,
  input  logic     exe_write,
  input  reg_idx_t rd,
  input  word_t    res_mask,
  input  word_t    res,
  input  reg_idx_t ra,
  input  reg_idx_t rb,
  input  reg_idx_t rc,
  output word_t    o0,
  output word_t    o1,
  output word_t    o2,
  input  reg_idx_t rd_addr,
  output word_t    rd_data,
  output logic     done
);

  // Register file
  word_t regs [`MPU_NUM_REGS];

  // Destination with the result lane replaced
  word_t merged;

  assign merged = (regs[rd] & ~res_mask) | (res & res_mask);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MPU_NUM_REGS; i++) begin
        regs[i] <= word_t'(0);
      end
      done <= 1'b0;
    end else begin
      if (wr_en) begin
        regs[wr_addr] <= wr_data;
      end
      // Later assignment, so the result beats a host write to the same register
      if (exe_valid && exe_write) begin
        regs[rd] <= merged;
      end
      // One pulse per instruction, none-class included
      done <= exe_valid;
    end
  end

  // Operand reads for the ALU
  assign o0 = regs[ra];
  assign o1 = regs[rb];
  assign o2 = regs[rc];

  // Host observation port
  assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

// ==== hdl/mpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpu_core
  import mpu_data_pkg::*, mpu_isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     instr_valid,
  input  instr_t   instr,
  input  logic     wr_en,
  input  reg_idx_t wr_addr,
  input  word_t    wr_data,
  input  reg_idx_t rd_addr,
  output word_t    rd_data,
  output logic     done
);

  // Decode to execute and result stages
  logic     exe_valid;
  logic     exe_write;
  opcode_t  exe_op;
  word_t    field_mask;
  word_t    res_mask;
  bit_off_t off0;
  bit_off_t off1;
  bit_off_t off2;
  bit_off_t off_res;
  reg_idx_t ra;
  reg_idx_t rb;
  reg_idx_t rc;
  reg_idx_t rd;

  // Operands from the register file and the lane-aligned result
  word_t o0;
  word_t o1;
  word_t o2;
  word_t res;

  mpu_decode mpu_decode_inst (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .exe_valid   (exe_valid),
    .exe_write   (exe_write),
    .exe_op      (exe_op),
    .field_mask  (field_mask),
    .res_mask    (res_mask),
    .off0        (off0),
    .off1        (off1),
    .off2        (off2),
    .off_res     (off_res),
    .ra          (ra),
    .rb          (rb),
    .rc          (rc),
    .rd          (rd)
  );

  // Purely combinational in the cycle after issue
  mpu_alu mpu_alu_inst (
    .exe_op     (exe_op),
    .field_mask (field_mask),
    .off0       (off0),
    .off1       (off1),
    .off2       (off2),
    .off_res    (off_res),
    .o0         (o0),
    .o1         (o1),
    .o2         (o2),
    .res        (res)
  );

  mpu_result mpu_result_inst (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .exe_valid (exe_valid),
    .exe_write (exe_write),
    .rd        (rd),
    .res_mask  (res_mask),
    .res       (res),
    .ra        (ra),
    .rb        (rb),
    .rc        (rc),
    .o0        (o0),
    .o1        (o1),
    .o2        (o2),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .done      (done)
  );

endmodule

`default_nettype wire

// ==== test/mpu_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mpu_consts.svh"

module mpu_core_tb;

  // Stimulus length and watchdog budget
  localparam int NUM_RANDOM   = 300;
  localparam int NUM_DIRECTED = 150;
  localparam int MARGIN_NS    = 1000;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic        wr_en;
  logic [1:0]  wr_addr;
  logic [63:0] wr_data;
  logic [1:0]  rd_addr;
  logic [63:0] rd_data;
  logic        done;

  // Reference model of the register file and the two-stage flow
  logic [63:0] model_regs [4];
  logic        pend_valid;
  logic [31:0] pend_instr;
  logic [1:0]  done_pipe;
  logic [63:0] exp_rd;

  int     errors;
  int     issued;
  integer seed;

  mpu_core mpu_core_inst (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .done        (done)
  );

  always #5 clk = ~clk;

  // Field layout, low to high
  function automatic logic [31:0] encode(input logic [3:0] op, input logic [1:0] size,
      input logic [2:0] s0, input logic [2:0] s1, input logic [2:0] s2,
      input logic [2:0] sres, input logic [1:0] ra, input logic [1:0] rb,
      input logic [1:0] rc, input logic [1:0] rd);
    return {6'b0, rd, rc, rb, ra, sres, s2, s1, s0, size, op};
  endfunction

  // Bitwise reference of one instruction applied to its destination
  function automatic logic [63:0] model_exec(input logic [63:0] dst, input logic [63:0] va,
      input logic [63:0] vb, input logic [63:0] vc, input logic [31:0] ins);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [63:0] r;
    int w;
    int oa;
    int ob;
    int oc;
    int ores;
    int i;
    w    = 8 << ins[`MPU_SIZE_HI:`MPU_SIZE_LO];
    // Selector times width, wrapped to 6 bits
    oa   = (int'(ins[`MPU_S0_HI:`MPU_S0_LO]) * w) % 64;
    ob   = (int'(ins[`MPU_S1_HI:`MPU_S1_LO]) * w) % 64;
    oc   = (int'(ins[`MPU_S2_HI:`MPU_S2_LO]) * w) % 64;
    ores = (int'(ins[`MPU_SRES_HI:`MPU_SRES_LO]) * w) % 64;
    a = '0;
    b = '0;
    c = '0;
    for (i = 0; i < w; i++) begin
      a[i] = va[oa + i];
      b[i] = vb[ob + i];
      c[i] = vc[oc + i];
    end
    case (ins[`MPU_OP_HI:`MPU_OP_LO])
      `MPU_OP_MASK: begin
        r = 64'd1;
        // b set means zero forbidden, c clear means one forbidden
        for (i = 0; i < w; i++) begin
          if ((b[i] && !a[i]) || (a[i] && !c[i])) r = 64'd0;
        end
      end
      `MPU_OP_CMP: begin
        r = 64'd1;
        for (i = 0; i < w; i++) begin
          if (c[i] && (a[i] != b[i])) r = 64'd0;
        end
      end
      `MPU_OP_LT:  r = (a < b) ? 64'd1 : 64'd0;
      `MPU_OP_ADD: r = b + c;
      default:     return dst;
    endcase
    // Only w bits are copied, so the sum is truncated here
    for (i = 0; i < w; i++) begin
      dst[ores + i] = r[i];
    end
    return dst;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < 4; k++) begin
        model_regs[k] <= '0;
      end
      pend_valid <= 1'b0;
      done_pipe  <= 2'b00;
    end else begin
      if (wr_en) begin
        model_regs[wr_addr] <= wr_data;
      end
      // Later assignment wins over the host write
      if (pend_valid && pend_instr[3:0] >= `MPU_OP_MASK && pend_instr[3:0] <= `MPU_OP_ADD) begin
        model_regs[pend_instr[`MPU_RD_HI:`MPU_RD_LO]] <= model_exec(
          model_regs[pend_instr[`MPU_RD_HI:`MPU_RD_LO]],
          model_regs[pend_instr[`MPU_RA_HI:`MPU_RA_LO]],
          model_regs[pend_instr[`MPU_RB_HI:`MPU_RB_LO]],
          model_regs[pend_instr[`MPU_RC_HI:`MPU_RC_LO]], pend_instr);
      end
      pend_valid <= instr_valid;
      pend_instr <= instr;
      done_pipe  <= {done_pipe[0], instr_valid};
    end
  end

  assign exp_rd = model_regs[rd_addr];

  // Observation port against the model, rd_addr rotates every cycle
  assert property (@(posedge clk) disable iff (rst) rd_data == exp_rd)
    else begin
      errors++;
      $display("ERR %0t: r%0d reads %h, expected %h", $time, $sampled(rd_addr),
        $sampled(rd_data), $sampled(exp_rd));
    end

  // One done pulse two edges after each issue
  assert property (@(posedge clk) disable iff (rst) done == done_pipe[1])
    else begin
      errors++;
      $display("ERR %0t: done is %b, expected %b", $time, $sampled(done),
        $sampled(done_pipe[1]));
    end

  // Strobes drop unless the caller raises them again
  task automatic next_cycle();
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    wr_en       = 1'b0;
    rd_addr     = rd_addr + 2'd1;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic issue(input logic [31:0] ins);
    next_cycle();
    instr_valid = 1'b1;
    instr       = ins;
    issued++;
  endtask

  task automatic host_write(input logic [1:0] addr, input logic [63:0] data);
    next_cycle();
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
  endtask

  initial begin
    #((NUM_DIRECTED + NUM_RANDOM) * 10 + MARGIN_NS);
    $display("Run timed out before the tests finished");
    $display("Checks failed");
    $finish;
  end

  initial begin
    int          size;
    int          sel;
    int          op;
    int          n;
    logic [31:0] rnd;
    clk         = 1'b0;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    wr_en       = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    rd_addr     = '0;
    errors      = 0;
    issued      = 0;
    seed        = 32'hf6ae6950;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Registers read zero, then host load
    idle(4);
    host_write(2'd0, 64'h0123_4567_89ab_cdef);
    host_write(2'd1, 64'hfedc_ba98_7654_3210);
    host_write(2'd2, 64'h0f1e_2d3c_4b5a_6978);
    host_write(2'd3, 64'ha5a5_5a5a_c3c3_3c3c);
    idle(4);

    // Add through every size and lane, back to back
    for (size = 0; size < 4; size++) begin
      for (sel = 0; sel < 8; sel++) begin
        issue(encode(`MPU_OP_ADD, 2'(size), 3'(sel), 3'(sel), 3'(7 - sel), 3'(sel),
          2'd0, 2'd1, 2'd2, 2'd3));
      end
    end
    idle(3);

    // Each boolean result stays in r3 for four cycles
    // so the rotating read port sees every outcome
    // Mask check, all zeros allowed and all ones allowed
    host_write(2'd1, 64'h0);
    host_write(2'd2, ~64'h0);
    issue(encode(`MPU_OP_MASK, 2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 2'd0, 2'd1, 2'd2, 2'd3));
    idle(3);
    // Zeros forbidden everywhere fails on r0
    host_write(2'd1, ~64'h0);
    issue(encode(`MPU_OP_MASK, 2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 2'd0, 2'd1, 2'd2, 2'd3));
    idle(3);
    issue(encode(`MPU_OP_MASK, 2'd0, 3'd2, 3'd1, 3'd3, 3'd5, 2'd2, 2'd0, 2'd2, 2'd3));
    idle(3);
    // Equality, same source then differing sources
    issue(encode(`MPU_OP_CMP, 2'd2, 3'd1, 3'd1, 3'd0, 3'd1, 2'd0, 2'd0, 2'd2, 2'd3));
    idle(3);
    issue(encode(`MPU_OP_CMP, 2'd1, 3'd0, 3'd0, 3'd0, 3'd2, 2'd0, 2'd1, 2'd2, 2'd3));
    idle(3);
    // Less-than in both directions
    host_write(2'd1, 64'd5);
    host_write(2'd2, 64'd9);
    issue(encode(`MPU_OP_LT, 2'd0, 3'd0, 3'd0, 3'd0, 3'd4, 2'd1, 2'd2, 2'd0, 2'd3));
    idle(3);
    issue(encode(`MPU_OP_LT, 2'd0, 3'd0, 3'd0, 3'd0, 3'd6, 2'd2, 2'd1, 2'd0, 2'd3));
    idle(3);

    // None and unknown opcodes still complete
    for (op = 0; op < 16; op++) begin
      if (op == 0 || op > 4) begin
        issue(encode(4'(op), 2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 2'd0, 2'd1, 2'd2, 2'd3));
      end
    end
    idle(3);

    // Second add reads r0 right after the first writes it
    issue(encode(`MPU_OP_ADD, 2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 2'd0, 2'd1, 2'd2, 2'd0));
    issue(encode(`MPU_OP_ADD, 2'd2, 3'd0, 3'd1, 3'd0, 3'd0, 2'd0, 2'd0, 2'd0, 2'd3));
    // Host write lands on the result edge of r2
    issue(encode(`MPU_OP_ADD, 2'd1, 3'd0, 3'd0, 3'd3, 3'd2, 2'd0, 2'd1, 2'd3, 2'd2));
    host_write(2'd2, 64'h1111_2222_3333_4444);
    idle(3);

    // Random mix with occasional host writes
    for (n = 0; n < NUM_RANDOM; n++) begin
      next_cycle();
      if (($random(seed) & 3) != 0) begin
        rnd = $random(seed);
        // Bias half of them toward real opcodes
        if (rnd[31]) rnd[3:0] = 4'(1 + ($unsigned($random(seed)) % 4));
        instr_valid = 1'b1;
        instr       = rnd;
        issued++;
      end
      if (($random(seed) & 7) == 0) begin
        wr_en   = 1'b1;
        wr_addr = 2'($random(seed));
        wr_data = {$random(seed), $random(seed)};
      end
    end
    idle(4);

    $display("Summary: %0d instructions issued, %0d errors", issued, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/mpu_data_pkg.sv
common/mpu_isa_pkg.sv
hdl/mpu_decode.sv
mpu_alu/mpu_alu.sv
hdl/mpu_result.sv
hdl/mpu_core.sv
test/mpu_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the MPU core testbench

TOP := mpu_core_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
